// ==== Makefile ====
TOP       ?= tb_ooo_core
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing -Wall
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without passing"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/core_cfg_pkg.sv ====
// back end sizing constants
package core_cfg_pkg;

    ////////////////////////////////////////////////////////////
    // datapath and register spaces
    ////////////////////////////////////////////////////////////
    localparam int XLEN       = 32;
    localparam int AREG_NUM   = 32;                   // rv32 integer regs
    localparam int AREG_LEN   = 5;
    localparam int PREG_NUM   = 48;
    localparam int PREG_LEN   = 6;
    localparam int FREE_NUM   = PREG_NUM - AREG_NUM;  // pregs not mapped at reset
    localparam int FREE_LEN   = 4;

    ////////////////////////////////////////////////////////////
    // queue depths and latencies
    ////////////////////////////////////////////////////////////
    localparam int ROB_SIZE   = 8;
    localparam int ROB_LEN    = 3;
    localparam int RS_SIZE    = 4;                    // per station
    localparam int MUL_STAGES = 3;                    // issue to cdb

    localparam int ZERO_REG   = 0;                    // x0, also its fixed preg

endpackage

// ==== rtl/core_types_pkg.sv ====
// back end packet types
package core_types_pkg;

    typedef logic [core_cfg_pkg::XLEN-1:0]     word_t;
    typedef logic [core_cfg_pkg::AREG_LEN-1:0] areg_t;
    typedef logic [core_cfg_pkg::PREG_LEN-1:0] preg_t;
    typedef logic [core_cfg_pkg::ROB_LEN-1:0]  rob_idx_t;

    typedef enum logic {FU_ALU, FU_MUL} fu_kind_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLL, ALU_SRL, ALU_SLT
    } alu_func_t;

    typedef enum logic [1:0] {MUL_MUL, MUL_MULH, MUL_MULHU} mul_func_t;

    // decoded instruction from the front end
    typedef struct packed {
        logic      valid;
        fu_kind_t  fu_kind;
        alu_func_t alu_func;
        mul_func_t mul_func;
        areg_t     rs1;
        areg_t     rs2;
        logic      use_imm;
        word_t     imm;       // already sign extended
        areg_t     rd;
    } dispatch_pkt_t;

    typedef struct packed {
        logic  ready;
        preg_t tag;           // producer preg while not ready
        word_t value;
    } operand_t;

    typedef struct packed {
        alu_func_t alu_func;
        operand_t  opa;
        operand_t  opb;
        preg_t     dest;
        rob_idx_t  rob;
    } alu_payload_t;

    typedef struct packed {
        mul_func_t mul_func;
        operand_t  opa;
        operand_t  opb;
        preg_t     dest;
        rob_idx_t  rob;
    } mul_payload_t;

    typedef struct packed {
        logic     valid;
        preg_t    dest;
        rob_idx_t rob;
        word_t    value;
    } cdb_pkt_t;

    typedef struct packed {
        logic  valid;
        areg_t rd;
        word_t value;
    } commit_pkt_t;

endpackage

// ==== rtl/exec_units.sv ====
// alu, pipelined multiplier and cdb mux
`timescale 1ns/1ns

module exec_units (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         alu_valid,
    input  core_types_pkg::alu_payload_t alu_in,
    input  logic                         mul_valid,
    input  core_types_pkg::mul_payload_t mul_in,
    output logic                         alu_ready,
    output core_types_pkg::cdb_pkt_t     cdb
);
    import core_cfg_pkg::*;
    import core_types_pkg::*;

    typedef struct packed {
        logic                valid;
        mul_func_t           func;
        preg_t               dest;
        rob_idx_t            rob;
        logic [2*XLEN-1:0]   prod;
    } mul_stage_t;

    word_t             alu_a;
    word_t             alu_b;
    word_t             alu_res;
    cdb_pkt_t          alu_q;
    logic [XLEN:0]     mul_a_ext;
    logic [XLEN:0]     mul_b_ext;
    logic [2*XLEN+1:0] mul_prod;
    mul_stage_t        mul_q [MUL_STAGES];
    word_t             mul_res;

    ////////////////////////////////////////////////////////////
    // alu, one cycle
    ////////////////////////////////////////////////////////////
    assign alu_a = alu_in.opa.value;
    assign alu_b = alu_in.opb.value;

    always_comb begin
        unique case (alu_in.alu_func)
            ALU_ADD: alu_res = alu_a + alu_b;
            ALU_SUB: alu_res = alu_a - alu_b;
            ALU_AND: alu_res = alu_a & alu_b;
            ALU_OR:  alu_res = alu_a | alu_b;
            ALU_XOR: alu_res = alu_a ^ alu_b;
            ALU_SLL: alu_res = alu_a << alu_b[4:0];
            ALU_SRL: alu_res = alu_a >> alu_b[4:0];
            ALU_SLT: alu_res = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_q.valid <= 1'b0;
        end else begin
            alu_q.valid <= alu_valid;
        end
        alu_q.dest  <= alu_in.dest;
        alu_q.rob   <= alu_in.rob;
        alu_q.value <= alu_res;
    end

    ////////////////////////////////////////////////////////////
    // multiplier, MUL_STAGES deep
    ////////////////////////////////////////////////////////////
    // one extra sign bit covers signed and unsigned high halves
    assign mul_a_ext = {(mul_in.mul_func == MUL_MULH) & mul_in.opa.value[XLEN-1],
                        mul_in.opa.value};
    assign mul_b_ext = {(mul_in.mul_func == MUL_MULH) & mul_in.opb.value[XLEN-1],
                        mul_in.opb.value};
    assign mul_prod  = $signed(mul_a_ext) * $signed(mul_b_ext);

    always_ff @(posedge clk) begin
        mul_q[0] <= {mul_valid, mul_in.mul_func, mul_in.dest, mul_in.rob,
                     mul_prod[2*XLEN-1:0]};
        for (int s = 1; s < MUL_STAGES; s++) begin
            mul_q[s] <= mul_q[s-1];              // later stages give retiming room
        end
        if (!rst_n) begin
            for (int s = 0; s < MUL_STAGES; s++) begin
                mul_q[s].valid <= 1'b0;
            end
        end
    end

    assign mul_res = (mul_q[MUL_STAGES-1].func == MUL_MUL) ?
                     mul_q[MUL_STAGES-1].prod[XLEN-1:0] :
                     mul_q[MUL_STAGES-1].prod[2*XLEN-1:XLEN];

    ////////////////////////////////////////////////////////////
    // cdb, multiplier first
    ////////////////////////////////////////////////////////////
    assign alu_ready = !mul_q[MUL_STAGES-2].valid;  // mul takes the bus next cycle

    always_comb begin
        cdb = alu_q;
        if (mul_q[MUL_STAGES-1].valid) begin
            cdb.valid = 1'b1;
            cdb.dest  = mul_q[MUL_STAGES-1].dest;
            cdb.rob   = mul_q[MUL_STAGES-1].rob;
            cdb.value = mul_res;
        end
    end

    // relies on the alu station honoring alu_ready a cycle earlier
    a_cdb_collision: assert property (@(posedge clk) disable iff (!rst_n)
        !(mul_q[MUL_STAGES-1].valid && alu_q.valid))
        else $error("alu and multiplier both on cdb");

endmodule

// ==== rtl/ooo_core.sv ====
// out-of-order back end top
`timescale 1ns/1ns

module ooo_core (
    input  logic                          clk,
    input  logic                          rst_n,
    input  core_types_pkg::dispatch_pkt_t dispatch,
    output logic                          stall,
    output core_types_pkg::commit_pkt_t   commit
);
    import core_cfg_pkg::*;
    import core_types_pkg::*;

    logic         accept;
    logic         has_rd;
    logic         rob_full;
    logic         alu_full;
    logic         mul_full;
    preg_t        tag_a, tag_b;
    preg_t        new_preg, old_preg, dest_preg;
    logic         release_valid;
    preg_t        release_preg;
    operand_t     rf_opa, rf_opb, opb_sel;
    rob_idx_t     rob_tail;
    alu_payload_t alu_pl, alu_issue;
    mul_payload_t mul_pl, mul_issue;
    logic         alu_issue_valid, mul_issue_valid;
    logic         alu_ready;
    cdb_pkt_t     cdb;

    ////////////////////////////////////////////////////////////
    // dispatch handshake and payload build
    ////////////////////////////////////////////////////////////
    assign stall  = rob_full || ((dispatch.fu_kind == FU_MUL) ? mul_full : alu_full);
    assign accept = dispatch.valid && !stall;
    assign has_rd = dispatch.rd != areg_t'(ZERO_REG);
    assign dest_preg = has_rd ? new_preg : preg_t'(ZERO_REG);  // x0 results land in preg 0

    always_comb begin
        opb_sel = rf_opb;
        if (dispatch.use_imm) begin
            opb_sel = '{ready: 1'b1, tag: preg_t'(ZERO_REG), value: dispatch.imm};
        end
    end

    assign alu_pl = '{alu_func: dispatch.alu_func, opa: rf_opa, opb: opb_sel,
                      dest: dest_preg, rob: rob_tail};
    assign mul_pl = '{mul_func: dispatch.mul_func, opa: rf_opa, opb: opb_sel,
                      dest: dest_preg, rob: rob_tail};

    ////////////////////////////////////////////////////////////
    // rename and operand read
    ////////////////////////////////////////////////////////////
    rename_map rename (
        .clk(clk), .rst_n(rst_n),
        .req_valid(accept),
        .rs1(dispatch.rs1), .rs2(dispatch.rs2), .rd(dispatch.rd),
        .tag_a(tag_a), .tag_b(tag_b),
        .new_preg(new_preg), .old_preg(old_preg),
        .release_valid(release_valid), .release_preg(release_preg)
    );

    phys_regfile prf (
        .clk(clk), .rst_n(rst_n),
        .tag_a(tag_a), .tag_b(tag_b),
        .alloc_valid(accept && has_rd), .alloc_preg(new_preg),
        .cdb(cdb),
        .opa(rf_opa), .opb(rf_opb)
    );

    ////////////////////////////////////////////////////////////
    // stations, units, rob
    ////////////////////////////////////////////////////////////
    rsv_station #(.payload_t(alu_payload_t)) alu_rs (
        .clk(clk), .rst_n(rst_n),
        .in_valid(accept && dispatch.fu_kind == FU_ALU), .in_payload(alu_pl),
        .cdb(cdb), .fu_ready(alu_ready), .full(alu_full),
        .issue_valid(alu_issue_valid), .issue_payload(alu_issue)
    );

    rsv_station #(.payload_t(mul_payload_t)) mul_rs (
        .clk(clk), .rst_n(rst_n),
        .in_valid(accept && dispatch.fu_kind == FU_MUL), .in_payload(mul_pl),
        .cdb(cdb), .fu_ready(1'b1), .full(mul_full),          // fully pipelined
        .issue_valid(mul_issue_valid), .issue_payload(mul_issue)
    );

    exec_units fu (
        .clk(clk), .rst_n(rst_n),
        .alu_valid(alu_issue_valid), .alu_in(alu_issue),
        .mul_valid(mul_issue_valid), .mul_in(mul_issue),
        .alu_ready(alu_ready), .cdb(cdb)
    );

    reorder_buffer rob (
        .clk(clk), .rst_n(rst_n),
        .alloc_valid(accept), .alloc_rd(dispatch.rd), .alloc_old_preg(old_preg),
        .cdb(cdb), .tail(rob_tail), .full(rob_full), .commit(commit),
        .release_valid(release_valid), .release_preg(release_preg)
    );

endmodule

// ==== rtl/phys_regfile.sv ====
// physical register file
`timescale 1ns/1ns

module phys_regfile (
    input  logic                     clk,
    input  logic                     rst_n,
    input  core_types_pkg::preg_t    tag_a,
    input  core_types_pkg::preg_t    tag_b,
    input  logic                     alloc_valid,
    input  core_types_pkg::preg_t    alloc_preg,
    input  core_types_pkg::cdb_pkt_t cdb,
    output core_types_pkg::operand_t opa,
    output core_types_pkg::operand_t opb
);
    import core_cfg_pkg::*;
    import core_types_pkg::*;

    word_t               value_q [PREG_NUM];
    logic [PREG_NUM-1:0] ready_q;
    logic                cdb_wr;

    assign cdb_wr = cdb.valid && (cdb.dest != preg_t'(ZERO_REG));  // preg 0 stays zero

    // stored value, or the result on the cdb this cycle
    function automatic operand_t read_port(preg_t tag);
        operand_t op;
        op.tag   = tag;
        op.ready = ready_q[tag];
        op.value = value_q[tag];
        if (cdb_wr && cdb.dest == tag) begin
            op.ready = 1'b1;
            op.value = cdb.value;
        end
        return op;
    endfunction

    always_comb begin
        opa = read_port(tag_a);
        opb = read_port(tag_b);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ready_q <= '1;                    // all arch values zero and ready
            for (int i = 0; i < PREG_NUM; i++) begin
                value_q[i] <= '0;
            end
        end else begin
            if (cdb_wr) begin
                value_q[cdb.dest] <= cdb.value;
                ready_q[cdb.dest] <= 1'b1;
            end
            if (alloc_valid) ready_q[alloc_preg] <= 1'b0;  // free preg, never on cdb
        end
    end

endmodule

// ==== rtl/rename_map.sv ====
// register map table and free list
`timescale 1ns/1ns

module rename_map (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  core_types_pkg::areg_t rs1,
    input  core_types_pkg::areg_t rs2,
    input  core_types_pkg::areg_t rd,
    output core_types_pkg::preg_t tag_a,
    output core_types_pkg::preg_t tag_b,
    output core_types_pkg::preg_t new_preg,
    output core_types_pkg::preg_t old_preg,
    input  logic                  release_valid,
    input  core_types_pkg::preg_t release_preg
);
    import core_cfg_pkg::*;
    import core_types_pkg::*;

    preg_t               map_q [AREG_NUM];     // arch -> phys
    preg_t               free_q [FREE_NUM];    // circular free list
    logic [FREE_LEN-1:0] fl_head;
    logic [FREE_LEN-1:0] fl_tail;
    logic [FREE_LEN:0]   fl_count;
    logic                pop;

    assign pop      = req_valid && (rd != areg_t'(ZERO_REG));  // x0 never renamed
    assign tag_a    = map_q[rs1];
    assign tag_b    = map_q[rs2];
    assign new_preg = free_q[fl_head];
    assign old_preg = map_q[rd];                // released again at commit

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // identity map, upper pregs start free
            for (int i = 0; i < AREG_NUM; i++) begin
                map_q[i] <= preg_t'(i);
            end
            for (int i = 0; i < FREE_NUM; i++) begin
                free_q[i] <= preg_t'(AREG_NUM + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;                      // full list, head == tail
            fl_count <= (FREE_LEN+1)'(FREE_NUM);
        end else begin
            if (pop) begin
                map_q[rd] <= free_q[fl_head];
                fl_head   <= fl_head + 1'b1;
            end
            if (release_valid) begin
                free_q[fl_tail] <= release_preg;
                fl_tail         <= fl_tail + 1'b1;
            end
            fl_count <= fl_count + release_valid - pop;
        end
    end

    // rob depth bounds the pregs in flight below the free list size
    a_fl_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> fl_count != '0)
        else $error("free list underflow");

endmodule

// ==== rtl/reorder_buffer.sv ====
// reorder buffer with in-order commit
`timescale 1ns/1ns

module reorder_buffer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        alloc_valid,
    input  core_types_pkg::areg_t       alloc_rd,
    input  core_types_pkg::preg_t       alloc_old_preg,
    input  core_types_pkg::cdb_pkt_t    cdb,
    output core_types_pkg::rob_idx_t    tail,
    output logic                        full,
    output core_types_pkg::commit_pkt_t commit,
    output logic                        release_valid,
    output core_types_pkg::preg_t       release_preg
);
    import core_cfg_pkg::*;
    import core_types_pkg::*;

    typedef struct packed {
        logic  done;
        areg_t rd;
        preg_t old_preg;   // mapping overwritten by this instruction
        word_t value;
    } rob_entry_t;

    rob_entry_t          entry_q [ROB_SIZE];
    logic [ROB_SIZE-1:0] busy_q;
    rob_idx_t            head;
    logic [ROB_LEN:0]    count;
    logic                do_commit;
    logic                head_has_rd;

    assign full        = (count == ROB_SIZE);
    assign do_commit   = busy_q[head] && entry_q[head].done;
    assign head_has_rd = entry_q[head].rd != areg_t'(ZERO_REG);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head          <= '0;
            tail          <= '0;
            count         <= '0;
            busy_q        <= '0;
            commit        <= '0;
            release_valid <= 1'b0;
        end else begin
            if (alloc_valid) begin
                busy_q[tail] <= 1'b1;
                tail         <= tail + 1'b1;
            end
            if (do_commit) begin
                busy_q[head] <= 1'b0;
                head         <= head + 1'b1;
            end
            count         <= count + alloc_valid - do_commit;
            commit.valid  <= do_commit;
            release_valid <= do_commit && head_has_rd;  // x0 held no free preg
        end
        commit.rd    <= entry_q[head].rd;
        commit.value <= head_has_rd ? entry_q[head].value : '0;
        release_preg <= entry_q[head].old_preg;
    end

    // entry payload, completion from the cdb
    always_ff @(posedge clk) begin
        if (cdb.valid) begin
            entry_q[cdb.rob].done  <= 1'b1;
            entry_q[cdb.rob].value <= cdb.value;
        end
        if (alloc_valid) begin
            entry_q[tail] <= '{done: 1'b0, rd: alloc_rd, old_preg: alloc_old_preg, value: '0};
        end
    end

    // each issued instruction broadcasts once to a live entry
    a_cdb_live_slot: assert property (@(posedge clk) disable iff (!rst_n)
        cdb.valid |-> busy_q[cdb.rob] && !entry_q[cdb.rob].done)
        else $error("cdb broadcast to empty rob slot");

endmodule

// ==== rtl/rsv_station.sv ====
// reservation station with cdb wakeup
`timescale 1ns/1ns

module rsv_station #(
    parameter type payload_t = core_types_pkg::alu_payload_t
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  payload_t                 in_payload,
    input  core_types_pkg::cdb_pkt_t cdb,
    input  logic                     fu_ready,
    output logic                     full,
    output logic                     issue_valid,
    output payload_t                 issue_payload
);
    import core_cfg_pkg::*;
    import core_types_pkg::*;

    payload_t                   entry_q [RS_SIZE];
    logic [RS_SIZE-1:0]         busy_q;
    logic [$clog2(RS_SIZE)-1:0] free_idx;
    logic [$clog2(RS_SIZE)-1:0] pick_idx;
    logic                       pick_found;

    // capture a matching broadcast
    function automatic operand_t wake(operand_t op, cdb_pkt_t c);
        operand_t res;
        res = op;
        if (c.valid && !op.ready && op.tag == c.dest) begin
            res.ready = 1'b1;
            res.value = c.value;
        end
        return res;
    endfunction

    // lowest free slot, lowest ready slot
    always_comb begin
        free_idx   = '0;
        pick_idx   = '0;
        pick_found = 1'b0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (!busy_q[i]) free_idx = i[$clog2(RS_SIZE)-1:0];
            if (busy_q[i] && entry_q[i].opa.ready && entry_q[i].opb.ready) begin
                pick_idx   = i[$clog2(RS_SIZE)-1:0];
                pick_found = 1'b1;
            end
        end
    end

    assign full          = &busy_q;
    assign issue_valid   = pick_found && fu_ready;
    assign issue_payload = entry_q[pick_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else begin
            if (issue_valid) busy_q[pick_idx] <= 1'b0;
            if (in_valid) busy_q[free_idx] <= 1'b1;   // never the issuing slot
        end
    end

    // payload storage, wakeup on every held operand
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            entry_q[i].opa <= wake(entry_q[i].opa, cdb);
            entry_q[i].opb <= wake(entry_q[i].opb, cdb);
        end
        if (in_valid) entry_q[free_idx] <= in_payload;  // regfile already forwarded
    end

    // top level stall must hold dispatch off a full station
    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !full)
        else $error("write to full station");

endmodule

// ==== sources.f ====
+incdir+test
rtl/core_cfg_pkg.sv
rtl/core_types_pkg.sv
rtl/rename_map.sv
rtl/phys_regfile.sv
rtl/rsv_station.sv
rtl/exec_units.sv
rtl/reorder_buffer.sv
rtl/ooo_core.sv
test/tb_ooo_core.sv

// ==== test/tb_checks.svh ====
// testbench random source and compare tasks
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// one galois step, taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 16'hB400;      // feedback from the bit shifted out
    return n;
endfunction

// n fresh bits, lfsr stepped once per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r          = {r[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
endfunction

task automatic check_commit(input commit_pkt_t got, input commit_pkt_t exp, input string what);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] t=%0t %s: got rd=%0d value=%h, expected rd=%0d value=%h",
                            $time, what, got.rd, got.value, exp.rd, exp.value));
    end
endtask

task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp));
    end
endtask

`endif

// ==== test/tb_ooo_core.sv ====
// out-of-order back end testbench
`timescale 1ns/1ns

module tb_ooo_core;
    import core_cfg_pkg::*;
    import core_types_pkg::*;

    localparam int N_ALU   = 8;
    localparam int N_CHAIN = 8;
    localparam int N_ORDER = 7;
    localparam int N_FILL  = 12;
    localparam int N_ZERO  = 3;
    localparam int N_RAND  = 200;
    localparam int TOTAL_INSTR    = N_ALU + N_CHAIN + N_ORDER + N_FILL + N_ZERO + N_RAND;
    localparam int TIMEOUT_CYCLES = 10 * TOTAL_INSTR + 200;   // margin for reset and drains
    localparam logic [15:0] LFSR_SEED = 16'd40995;

    logic          clock;
    logic          rst_n;
    dispatch_pkt_t dispatch;
    logic          stall;
    commit_pkt_t   commit_out;

    word_t         arch_q [AREG_NUM];   // reference architectural state
    commit_pkt_t   exp_q [$];           // expected commits, program order
    logic [15:0]   lfsr_state = LFSR_SEED;
    logic          stall_seen;
    int            cycle_count = 0;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "run stopped");
    endtask

    `include "tb_checks.svh"

    ooo_core uut (
        .clk(clock), .rst_n(rst_n),
        .dispatch(dispatch), .stall(stall), .commit(commit_out)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    function automatic word_t model_result(input dispatch_pkt_t p);
        word_t       a;
        word_t       b;
        longint      sa;
        longint      sb;
        logic [63:0] prod;
        a  = arch_q[p.rs1];
        b  = p.use_imm ? p.imm : arch_q[p.rs2];
        sa = $signed(a);                 // sign extended to 64 bits
        sb = $signed(b);
        if (p.fu_kind == FU_MUL) begin
            if (p.mul_func == MUL_MULH) prod = sa * sb;
            else prod = {32'b0, a} * {32'b0, b};
            return (p.mul_func == MUL_MUL) ? prod[31:0] : prod[63:32];
        end
        case (p.alu_func)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return (sa < sb) ? 32'd1 : 32'd0;   // slt
        endcase
    endfunction

    task automatic model_dispatch(input dispatch_pkt_t p);
        commit_pkt_t e;
        e.valid = 1'b1;
        e.rd    = p.rd;
        e.value = (p.rd == 5'd0) ? '0 : model_result(p);   // x0 reads as zero
        exp_q.push_back(e);
        if (p.rd != 5'd0) arch_q[p.rd] = e.value;
    endtask

    ////////////////////////////////////////////////////////////
    // instruction builders and dispatch driver
    ////////////////////////////////////////////////////////////
    function automatic dispatch_pkt_t alu_ri(alu_func_t f, areg_t rd, areg_t rs1, word_t imm);
        dispatch_pkt_t p;
        p          = '0;
        p.fu_kind  = FU_ALU;
        p.alu_func = f;
        p.rd       = rd;
        p.rs1      = rs1;
        p.use_imm  = 1'b1;
        p.imm      = imm;
        return p;
    endfunction

    function automatic dispatch_pkt_t op_rr(fu_kind_t k, alu_func_t af, mul_func_t mf,
                                            areg_t rd, areg_t rs1, areg_t rs2);
        dispatch_pkt_t p;
        p          = '0;
        p.fu_kind  = k;
        p.alu_func = af;
        p.mul_func = mf;
        p.rd       = rd;
        p.rs1      = rs1;
        p.rs2      = rs2;
        return p;
    endfunction

    // drive on the falling edge, hold while stalled
    task automatic send(input dispatch_pkt_t pkt);
        logic taken;
        taken     = 1'b0;
        pkt.valid = 1'b1;
        while (!taken) begin
            @(negedge clock);
            dispatch = pkt;
            #1;
            if (stall) stall_seen = 1'b1;
            else taken = 1'b1;                  // accepted at the coming rising edge
        end
        model_dispatch(pkt);
    endtask

    task automatic drain();
        @(negedge clock);
        dispatch = '0;
        while (exp_q.size() != 0) begin
            @(negedge clock);
            #1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////
    task automatic test_alu_imm();
        check_word(word_t'(commit_out.valid), '0, "commit.valid after reset");
        check_word(word_t'(stall), '0, "stall after reset");
        send(alu_ri(ALU_ADD, 5'd1, 5'd0, 32'd100));
        send(alu_ri(ALU_SUB, 5'd2, 5'd0, 32'd7));
        send(alu_ri(ALU_OR,  5'd3, 5'd0, 32'h0000_0f0f));
        send(alu_ri(ALU_XOR, 5'd4, 5'd0, 32'hffff_ff00));
        send(alu_ri(ALU_AND, 5'd5, 5'd0, 32'h1234_5678));
        send(alu_ri(ALU_SLT, 5'd6, 5'd0, 32'd5));
        send(alu_ri(ALU_SLL, 5'd7, 5'd0, 32'd3));
        send(alu_ri(ALU_SRL, 5'd8, 5'd0, 32'd1));
        drain();
    endtask

    task automatic test_dep_chain();
        send(alu_ri(ALU_ADD, 5'd1, 5'd0, 32'd1234));
        send(alu_ri(ALU_ADD, 5'd2, 5'd0, -32'sd567));
        send(op_rr(FU_MUL, ALU_ADD, MUL_MUL,   5'd3, 5'd1, 5'd2));
        send(op_rr(FU_MUL, ALU_ADD, MUL_MULH,  5'd4, 5'd3, 5'd2));
        send(op_rr(FU_MUL, ALU_ADD, MUL_MULHU, 5'd5, 5'd3, 5'd1));
        send(op_rr(FU_ALU, ALU_ADD, MUL_MUL,   5'd6, 5'd4, 5'd5));
        send(op_rr(FU_MUL, ALU_ADD, MUL_MUL,   5'd7, 5'd6, 5'd3));
        send(op_rr(FU_ALU, ALU_SLT, MUL_MUL,   5'd8, 5'd7, 5'd6));
        drain();
    endtask

    task automatic test_mul_order();
        send(op_rr(FU_MUL, ALU_ADD, MUL_MUL,   5'd9,  5'd1, 5'd2));
        send(op_rr(FU_MUL, ALU_ADD, MUL_MULH,  5'd10, 5'd2, 5'd2));
        send(op_rr(FU_MUL, ALU_ADD, MUL_MULHU, 5'd11, 5'd2, 5'd2));
        send(alu_ri(ALU_ADD, 5'd12, 5'd0, 32'd11));   // finish before the muls
        send(alu_ri(ALU_XOR, 5'd13, 5'd0, 32'h5a5a_0000));
        send(alu_ri(ALU_OR,  5'd14, 5'd0, 32'h0000_00c3));
        send(alu_ri(ALU_SUB, 5'd15, 5'd0, 32'd42));
        drain();
    endtask

    task automatic test_rob_fill();
        stall_seen = 1'b0;
        send(alu_ri(ALU_ADD, 5'd16, 5'd0, 32'd3));
        send(alu_ri(ALU_ADD, 5'd17, 5'd0, 32'd5));
        for (int i = 0; i < N_FILL - 2; i++) begin
            send(op_rr(FU_MUL, ALU_ADD, MUL_MUL, 5'd16, 5'd16, 5'd17));  // serial chain
        end
        drain();
        check_word(word_t'(stall_seen), 32'd1, "stall during dependent mul chain");
    endtask

    task automatic test_zero_reg();
        send(op_rr(FU_ALU, ALU_ADD, MUL_MUL, 5'd0, 5'd1, 5'd2));   // result dropped
        send(op_rr(FU_ALU, ALU_ADD, MUL_MUL, 5'd18, 5'd0, 5'd0));
        send(alu_ri(ALU_ADD, 5'd19, 5'd0, 32'd9));
        drain();
    endtask

    // small register window so the free list recycles often
    task automatic test_random();
        dispatch_pkt_t p;
        logic [11:0]   imm12;
        logic [1:0]    mf;
        for (int i = 0; i < N_RAND; i++) begin
            p     = '0;
            p.rd  = areg_t'(rand_bits(3));
            p.rs1 = areg_t'(rand_bits(3));
            p.rs2 = areg_t'(rand_bits(3));
            if (rand_bits(2) == 32'd0) begin
                mf         = 2'(rand_bits(2));
                p.fu_kind  = FU_MUL;
                p.mul_func = (mf == 2'd3) ? MUL_MULHU : mul_func_t'(mf);
            end else begin
                imm12      = 12'(rand_bits(12));
                p.fu_kind  = FU_ALU;
                p.alu_func = alu_func_t'(rand_bits(3));
                p.use_imm  = 1'(rand_bits(1));
                p.imm      = {{20{imm12[11]}}, imm12};
            end
            send(p);
        end
        drain();
    endtask

    ////////////////////////////////////////////////////////////
    // commit monitor, timeout, main sequence
    ////////////////////////////////////////////////////////////
    always @(negedge clock) begin
        commit_pkt_t exp;
        if (rst_n && commit_out.valid) begin
            if (exp_q.size() == 0) begin
                abort_run($sformatf("commit of x%0d at %0t with no instruction pending",
                                    commit_out.rd, $time));
            end else begin
                exp = exp_q.pop_front();
                check_commit(commit_out, exp, "commit");
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout after %0d cycles, %0d commits still missing",
                                cycle_count, exp_q.size()));
        end
    end

    initial begin
        rst_n      = 1'b0;
        dispatch   = '0;
        stall_seen = 1'b0;
        for (int i = 0; i < AREG_NUM; i++) arch_q[i] = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        test_alu_imm();
        test_dep_chain();
        test_mul_order();
        test_rob_fill();
        test_zero_reg();
        test_random();
        repeat (5) @(negedge clock);     // no stray commits after the last drain
        $display("No errors");
        $finish;
    end

endmodule
